//--- Bender.yml
package:
  name: wmb_ce

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/wmb_ce_pkg.sv
      - verilog/wmb_ce_entry.sv
      - verilog/wmb_ce_decode.sv
      - verilog/wmb_ce_pop_compare.sv
      - verilog/wmb_ce_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_wmb_ce.sv

//--- test/tb_wmb_ce.sv
`timescale 1ns/10ps
`include "wmb_ce_settings.svh"

module tb_wmb_ce
  import wmb_ce_pkg::*;
;

  logic                         wmb_clk;
  logic                         cpurst_b;
  ce_pop_info_t                 sq_pop;
  logic                         create_vld;
  logic                         create_dp_vld;
  logic                         pop_vld;
  logic                         async_flush;
  ce_create_ctl_t               create_ctl;
  logic                         rb_hit_idx;
  logic [`WMB_CE_WMB_ENTRY-1:0] wmb_entry_vld;
  logic                         dcache_valid;
  logic                         dcache_share;
  logic                         lm_sc_fail;
  logic                         ce_vld;
  ce_pop_info_t                 ce_info;
  logic [`WMB_CE_WMB_ENTRY-1:0] merge_ptr;
  logic [`WMB_CE_WMB_ENTRY-1:0] same_dcache_line;
  ce_req_t                      req;
  ce_attr_t                     attr;
  logic                         hit_sq_pop_dcache_line;
  logic                         merge_data_addr_hit;
  logic                         merge_data_stall;

  // Reference state of the entry
  logic           m_vld;
  logic           loaded;
  ce_pop_info_t   m_info;
  ce_create_ctl_t m_ctl;
  logic           m_hold;
  logic           m_hold_ff;
  ce_req_t        exp_req;
  ce_attr_t       exp_attr;
  logic [2:0]     exp_cmp;

  int errors;
  int timeouts;

  wmb_ce_top dut_i (.*);

  initial
  begin
    wmb_clk = 1'b0;
    forever #5 wmb_clk = ~wmb_clk;
  end

  //============================================================
  // Reference rules
  //============================================================

  // Hold is needed by wo_st, atomics and single-line dcache ops
  function automatic logic rb_hold_needed(input ce_pop_info_t i);
    logic dc;
    dc = !i.atomic && i.icc && (i.inst_type == 2'b10);
    return i.wo_st || i.atomic || (dc && (i.inst_mode != 2'b00));
  endfunction

  function automatic ce_attr_t expected_attr(input ce_pop_info_t i, input logic dvld,
                                             input logic dshr, input logic sc_fail);
    ce_attr_t a;
    logic st;
    logic stamo;
    logic sc;
    logic sf;
    logic dc;
    logic icc_nondc;
    logic line_ok;
    st        = !i.atomic && !i.icc && !i.sync_fence;
    sf        = !i.atomic && !i.icc && i.sync_fence;
    stamo     = i.atomic && (i.inst_type == 2'b00);
    sc        = i.atomic && (i.inst_type == 2'b01);
    dc        = !i.atomic && i.icc && (i.inst_type == 2'b10);
    icc_nondc = !i.atomic && i.icc && (i.inst_type != 2'b10);
    line_ok   = i.page.ca && dvld;
    a.merge_en         = i.wo_st;
    a.write_imme       = !i.wo_st;
    a.wb_data_success  = !sc;
    a.wb_cmplt_success = i.wo_st || icc_nondc || (dc && (i.inst_mode != 2'b00));
    a.dcache_inst      = dc;
    a.dcache_sw_inst   = dc && (i.inst_mode == 2'b10);
    a.ca_st_inst       = st && i.page.ca;
    a.bytes_vld_full   = (i.bytes_vld == {`WMB_CE_BYTES{1'b1}});
    a.read_dp_req = (st && i.page.ca && i.page.share && (dshr || !dvld))
                    || icc_nondc
                    || (dc && i.inst_mode[0] && i.page.ca
                        && ((i.inst_size[1:0] != 2'b00) || i.page.share))
                    || (sc && i.page.ca && i.page.share);
    a.write_biu_dp_req = (st && i.page.so) || sf
                         || (((st && !i.page.so) || stamo) && !line_ok)
                         || (sc && !line_ok && !sc_fail);
    return a;
  endfunction

  function automatic ce_req_t req_from_rules(input logic vld, input ce_create_ctl_t c,
                                             input logic hold_ff, input ce_pop_info_t i,
                                             input logic [`WMB_CE_WMB_ENTRY-1:0] ent_vld);
    ce_req_t r;
    logic wr_data;
    wr_data = i.atomic || (!i.icc && !i.sync_fence)
              || (i.icc && (i.inst_type == 2'b00) && i.inst_mode[0]);
    r.merge_wmb_req          = vld && c.merge && !c.stall;
    r.merge_wait_not_vld_req = vld && c.merge && c.stall;
    r.create_wmb_req         = vld && !hold_ff
                               && (!c.merge || ((c.merge_ptr & ent_vld) == '0));
    r.create_dp_req          = vld && (!c.merge || c.stall);
    r.create_data_req        = r.create_dp_req && wr_data;
    return r;
  endfunction

  // Line hit, quadword hit and privilege stall
  function automatic logic [2:0] pop_hits(input logic vld, input ce_pop_info_t i,
                                          input ce_pop_info_t p);
    logic line;
    logic qw;
    logic st;
    st   = !i.atomic && !i.icc && !i.sync_fence;
    line = (i.addr >> `WMB_CE_LINE_LSB) == (p.addr >> `WMB_CE_LINE_LSB);
    qw   = (i.addr >> `WMB_CE_QW_LSB) == (p.addr >> `WMB_CE_QW_LSB);
    return {vld && st && line, vld && i.wo_st && qw,
            vld && i.wo_st && qw && (i.priv_mode != p.priv_mode)};
  endfunction

  always @(posedge wmb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      m_vld     <= 1'b0;
      loaded    <= 1'b0;
      m_hold    <= 1'b0;
      m_hold_ff <= 1'b0;
    end
    else
    begin
      if (async_flush)
        m_vld <= 1'b0;
      else if (create_vld)
        m_vld <= 1'b1;
      else if (pop_vld)
        m_vld <= 1'b0;
      if (create_dp_vld)
      begin
        m_info    <= sq_pop;
        m_ctl     <= create_ctl;
        loaded    <= 1'b1;
        m_hold    <= create_ctl.hit_rb_idx;
        m_hold_ff <= create_ctl.hit_rb_idx;
      end
      else if (m_vld)
      begin
        m_hold    <= m_hold && rb_hit_idx && rb_hold_needed(m_info);
        m_hold_ff <= m_hold;
      end
    end
  end

  always_comb
  begin
    exp_req  = req_from_rules(m_vld, m_ctl, m_hold_ff, m_info, wmb_entry_vld);
    exp_attr = expected_attr(m_info, dcache_valid, dcache_share, lm_sc_fail);
    exp_cmp  = pop_hits(m_vld, m_info, sq_pop);
  end

  //============================================================
  // Checking assertions
  //============================================================

  a_vld: assert property (@(posedge wmb_clk) disable iff (!cpurst_b) ce_vld == m_vld)
    else begin
      errors++;
      $display("[FAIL] %0t: ce_vld %b, expected %b", $time, $sampled(ce_vld), $sampled(m_vld));
    end

  a_info: assert property (@(posedge wmb_clk) disable iff (!cpurst_b)
    loaded |-> (ce_info == m_info && merge_ptr == m_ctl.merge_ptr
                && same_dcache_line == m_ctl.same_dcache_line))
    else begin
      errors++;
      $display("[FAIL] %0t: payload %h, expected %h", $time, $sampled(ce_info),
               $sampled(m_info));
    end

  a_req: assert property (@(posedge wmb_clk) disable iff (!cpurst_b) req == exp_req)
    else begin
      errors++;
      $display("[FAIL] %0t: req %b, expected %b", $time, $sampled(req), $sampled(exp_req));
    end

  a_attr: assert property (@(posedge wmb_clk) disable iff (!cpurst_b)
    loaded |-> attr == exp_attr)
    else begin
      errors++;
      $display("[FAIL] %0t: attr %b, expected %b", $time, $sampled(attr), $sampled(exp_attr));
    end

  a_cmp: assert property (@(posedge wmb_clk) disable iff (!cpurst_b)
    {hit_sq_pop_dcache_line, merge_data_addr_hit, merge_data_stall} == exp_cmp)
    else begin
      errors++;
      $display("[FAIL] %0t: pop compare %b, expected %b", $time,
               $sampled({hit_sq_pop_dcache_line, merge_data_addr_hit, merge_data_stall}),
               $sampled(exp_cmp));
    end

  //============================================================
  // Stimulus helpers
  //============================================================

  function automatic logic coin();
    logic [31:0] w;
    w = $urandom();
    return w[0];
  endfunction

  function automatic logic [`WMB_CE_WMB_ENTRY-1:0] random_entry_vld();
    logic [31:0] w;
    w = $urandom();
    return w[`WMB_CE_WMB_ENTRY-1:0];
  endfunction

  function automatic ce_pop_info_t random_pop();
    ce_pop_info_t p;
    logic [63:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = {$urandom(), $urandom()};
    b = $urandom();
    c = $urandom();
    p.addr       = a[`WMB_CE_PA_WIDTH-1:0];
    p.page       = b[5:0];
    p.atomic     = b[6];
    p.icc        = b[7];
    p.wo_st      = b[8];
    p.sync_fence = b[9];
    p.inst_flush = b[10];
    p.inst_type  = ce_inst_type_e'(b[12:11]);
    p.inst_size  = b[15:13];
    p.inst_mode  = b[17:16];
    p.priv_mode  = b[19:18];
    p.bytes_vld  = (b[21:20] == 2'b00) ? '1 : c[`WMB_CE_BYTES-1:0];
    p.sq_ptr     = '0;
    p.sq_ptr[$urandom_range(0, `WMB_CE_SQ_PTR_W-1)] = 1'b1;
    return p;
  endfunction

  // Merge pointer is always one-hot
  function automatic ce_create_ctl_t make_ctl(input logic merge, input logic stall,
                                              input logic hold);
    ce_create_ctl_t c;
    c.merge            = merge;
    c.stall            = stall;
    c.merge_ptr        = '0;
    c.merge_ptr[$urandom_range(0, `WMB_CE_WMB_ENTRY-1)] = 1'b1;
    c.same_dcache_line = random_entry_vld();
    c.hit_rb_idx       = hold;
    return c;
  endfunction

  function automatic ce_pop_info_t plain_store(input logic wo);
    ce_pop_info_t p;
    p            = random_pop();
    p.atomic     = 1'b0;
    p.icc        = 1'b0;
    p.sync_fence = 1'b0;
    p.wo_st      = wo;
    p.page.so    = !wo;
    return p;
  endfunction

  task automatic step();
    @(posedge wmb_clk);
    #1;
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic create_entry(input ce_pop_info_t p, input ce_create_ctl_t c);
    sq_pop        = p;
    create_ctl    = c;
    create_vld    = 1'b1;
    create_dp_vld = 1'b1;
    step();
    create_vld    = 1'b0;
    create_dp_vld = 1'b0;
  endtask

  task automatic wait_create_wmb(input int limit, output int edges);
    edges = 0;
    while (!req.create_wmb_req && edges < limit)
    begin
      @(posedge wmb_clk);
      #1;
      edges++;
    end
    if (!req.create_wmb_req)
    begin
      timeouts++;
      $display("Timeout: create_wmb_req did not rise within %0d cycles", limit);
    end
  endtask

  //============================================================
  // Test sequence
  //============================================================

  initial
  begin
    int           edges;
    ce_pop_info_t p;
    ce_pop_info_t q;
    void'($urandom(32'h95ffd19e));
    errors        = 0;
    timeouts      = 0;
    cpurst_b      = 1'b0;
    sq_pop        = '0;
    create_ctl    = '0;
    create_vld    = 1'b0;
    create_dp_vld = 1'b0;
    pop_vld       = 1'b0;
    async_flush   = 1'b0;
    rb_hit_idx    = 1'b0;
    wmb_entry_vld = '0;
    dcache_valid  = 1'b0;
    dcache_share  = 1'b0;
    lm_sc_fail    = 1'b0;
    repeat (5) @(posedge wmb_clk);
    #1;
    cpurst_b = 1'b1;
    if (ce_vld !== 1'b0 || req !== '0)
      report_fail("entry not idle after reset");

    // Valid lifecycle
    create_entry(random_pop(), make_ctl(0, 0, 0));
    pop_vld = 1'b1;
    step();
    pop_vld     = 1'b0;
    async_flush = 1'b1;
    create_entry(random_pop(), make_ctl(0, 0, 0));
    async_flush = 1'b0;
    create_entry(random_pop(), make_ctl(0, 0, 0));
    pop_vld = 1'b1;
    create_entry(random_pop(), make_ctl(0, 0, 0));
    step();
    pop_vld = 1'b0;

    // Payload capture and hold with attributes under random line state
    for (int n = 0; n < 200; n++)
    begin
      create_entry(random_pop(), make_ctl(0, 0, 0));
      repeat (3)
      begin
        sq_pop       = random_pop();
        dcache_valid = coin();
        dcache_share = coin();
        lm_sc_fail   = coin();
        step();
      end
    end

    // Merge requests without a refill hold
    for (int m = 0; m < 4; m++)
    begin
      repeat (10)
      begin
        create_entry(random_pop(), make_ctl(m[1], m[0], 0));
        repeat (2)
        begin
          wmb_entry_vld = random_entry_vld();
          step();
        end
      end
    end

    // Refill index hold on a weakly ordered store
    rb_hit_idx = 1'b1;
    create_entry(plain_store(1'b1), make_ctl(0, 0, 1));
    repeat (4)
    begin
      if (req.create_wmb_req)
        report_fail("create_wmb_req high while refill index held");
      step();
    end
    rb_hit_idx = 1'b0;
    wait_create_wmb(10, edges);
    if (edges != 2)
      report_fail($sformatf("create_wmb_req rose %0d edges after release", edges));

    // Strongly ordered store ignores the hold condition
    rb_hit_idx = 1'b1;
    create_entry(plain_store(1'b0), make_ctl(0, 0, 1));
    wait_create_wmb(10, edges);
    if (edges != 2)
      report_fail($sformatf("create_wmb_req rose %0d edges after create", edges));
    rb_hit_idx = 1'b0;

    // Pop compare against mergeable, ordered and random entries
    for (int k = 0; k < 3; k++)
    begin
      p = (k == 2) ? random_pop() : plain_store(k == 0);
      create_entry(p, make_ctl(0, 0, 0));
      repeat (40)
      begin
        q = random_pop();
        case ($urandom_range(0, 2))
          0: q.addr[`WMB_CE_PA_WIDTH-1:`WMB_CE_QW_LSB] =
               p.addr[`WMB_CE_PA_WIDTH-1:`WMB_CE_QW_LSB];
          1: q.addr[`WMB_CE_PA_WIDTH-1:`WMB_CE_LINE_LSB] =
               p.addr[`WMB_CE_PA_WIDTH-1:`WMB_CE_LINE_LSB];
          default: ;
        endcase
        sq_pop = q;
        step();
      end
    end

    step();
    $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- verilog/wmb_ce_decode.sv
`timescale 1ns/10ps
`include "wmb_ce_settings.svh"

module wmb_ce_decode
  import wmb_ce_pkg::*;
(
  input  logic                         wmb_clk,
  input  logic                         cpurst_b,
  input  logic                         ce_vld,
  input  ce_pop_info_t                 ce_info,
  input  ce_create_ctl_t               ce_ctl,
  input  logic                         hit_rb_idx_ff,
  input  logic [`WMB_CE_WMB_ENTRY-1:0] wmb_entry_vld,
  input  logic                         dcache_valid,
  input  logic                         dcache_share,
  input  logic                         lm_sc_fail,
  output ce_class_e                    ce_class,
  output logic                         rb_hold_cond,
  output ce_req_t                      req,
  output ce_attr_t                     attr
);

  logic st_inst;
  logic so_st_inst;
  logic wo_st_inst;
  logic stamo_inst;
  logic sc_inst;
  logic atomic_inst;
  logic sync_fence_inst;
  logic tlbi_inst;
  logic dcache_inst;
  logic ctc_inst;
  logic write_data_inst;
  logic dcache_1line_inst;
  logic dcache_addr_inst;
  logic dcache_addr_not_l1;
  logic ca_line_valid;
  logic merge_not_vld;

  //============================================================
  // Classification
  //============================================================

  always_comb
  begin
    if (ce_info.atomic)
    begin
      case (ce_info.inst_type)
        TYPE_00: ce_class = CLS_STAMO;
        TYPE_01: ce_class = CLS_SC;
        default: ce_class = CLS_AMO_OTHER;
      endcase
    end
    else if (!ce_info.icc)
      ce_class = ce_info.sync_fence ? CLS_SYNC_FENCE : CLS_ST;
    else
    begin
      case (ce_info.inst_type)
        TYPE_00:     ce_class = CLS_TLBI;
        TYPE_DCACHE: ce_class = CLS_DCACHE;
        default:     ce_class = CLS_ICC_OTHER;
      endcase
    end
  end

  assign st_inst         = (ce_class == CLS_ST);
  assign so_st_inst      = st_inst && ce_info.page.so;
  assign wo_st_inst      = st_inst && !ce_info.page.so;
  assign stamo_inst      = (ce_class == CLS_STAMO);
  assign sc_inst         = (ce_class == CLS_SC);
  assign atomic_inst     = stamo_inst || sc_inst || (ce_class == CLS_AMO_OTHER);
  assign sync_fence_inst = (ce_class == CLS_SYNC_FENCE);
  assign tlbi_inst       = (ce_class == CLS_TLBI);
  assign dcache_inst     = (ce_class == CLS_DCACHE);
  // Control transfer ops are the icc ops other than dcache
  assign ctc_inst        = tlbi_inst || (ce_class == CLS_ICC_OTHER);

  // tlbi by asid carries data
  assign write_data_inst = atomic_inst || st_inst || (tlbi_inst && ce_info.inst_mode[0]);

  assign dcache_1line_inst  = dcache_inst && (ce_info.inst_mode != 2'b00);
  assign dcache_addr_inst   = dcache_inst && ce_info.inst_mode[0];
  assign dcache_addr_not_l1 = dcache_addr_inst && (ce_info.inst_size[1:0] != 2'b00);

  assign rb_hold_cond = ce_info.wo_st || ce_info.atomic || dcache_1line_inst;

  //============================================================
  // Requests
  //============================================================

  assign merge_not_vld = |(ce_ctl.merge_ptr & ~wmb_entry_vld);

  assign req.merge_wmb_req          = ce_vld && ce_ctl.merge && !ce_ctl.stall;
  assign req.merge_wait_not_vld_req = ce_vld && ce_ctl.merge && ce_ctl.stall;
  assign req.create_wmb_req         = ce_vld && !hit_rb_idx_ff
                                      && (!ce_ctl.merge || merge_not_vld);
  assign req.create_dp_req          = ce_vld && (!ce_ctl.merge || ce_ctl.stall);
  assign req.create_data_req        = req.create_dp_req && write_data_inst;

  //============================================================
  // Entry attributes
  //============================================================

  assign attr.merge_en         = ce_info.wo_st;
  assign attr.write_imme       = !ce_info.wo_st;
  assign attr.wb_data_success  = !sc_inst;
  assign attr.wb_cmplt_success = ce_info.wo_st || ctc_inst || dcache_1line_inst;
  assign attr.dcache_inst      = dcache_inst;
  assign attr.dcache_sw_inst   = dcache_inst && (ce_info.inst_mode == 2'b10);
  assign attr.ca_st_inst       = st_inst && ce_info.page.ca;
  assign attr.bytes_vld_full   = &ce_info.bytes_vld;

  // Read path needed for coherent stores, icc ops and sc
  assign attr.read_dp_req =
      (st_inst && ce_info.page.ca && ce_info.page.share
       && (dcache_share || !dcache_valid))
      || ctc_inst
      || (dcache_addr_inst && ce_info.page.ca
          && (dcache_addr_not_l1 || ce_info.page.share))
      || (sc_inst && ce_info.page.ca && ce_info.page.share);

  // Cacheable line already held in the dcache
  assign ca_line_valid = ce_info.page.ca && dcache_valid;

  assign attr.write_biu_dp_req =
      so_st_inst
      || sync_fence_inst
      || ((wo_st_inst || stamo_inst) && !ca_line_valid)
      || (sc_inst && !ca_line_valid && !lm_sc_fail);

  //============================================================
  // Checks
  //============================================================

  // A valid entry always presents defined requests
  a_req_known: assert property (
    @(posedge wmb_clk) disable iff (!cpurst_b)
    ce_vld |-> !$isunknown(req)
  ) else $error("unknown request while the entry is valid");

endmodule

//--- verilog/wmb_ce_entry.sv
`timescale 1ns/10ps
`include "wmb_ce_settings.svh"

module wmb_ce_entry
  import wmb_ce_pkg::*;
(
  input  logic           wmb_clk,
  input  logic           cpurst_b,
  input  logic           async_flush,
  input  logic           create_vld,
  input  logic           create_dp_vld,
  input  logic           pop_vld,
  input  ce_pop_info_t   sq_pop,
  input  ce_create_ctl_t create_ctl,
  input  logic           rb_hit_idx,
  input  logic           rb_hold_cond,
  output logic           ce_vld,
  output ce_pop_info_t   ce_info,
  output ce_create_ctl_t ce_ctl,
  output logic           hit_rb_idx_ff
);

  logic hit_rb_idx;
  logic hit_rb_idx_nxt;

  //============================================================
  // Valid
  //============================================================

  // Flush beats create, create beats pop
  always_ff @(posedge wmb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ce_vld <= 1'b0;
    else if (async_flush)
      ce_vld <= 1'b0;
    else if (create_vld)
      ce_vld <= 1'b1;
    else if (pop_vld)
      ce_vld <= 1'b0;
  end

  //============================================================
  // Payload and merge decision
  //============================================================

  always_ff @(posedge wmb_clk)
  begin
    if (create_dp_vld)
    begin
      ce_info <= sq_pop;
      ce_ctl  <= create_ctl;
    end
  end

  //============================================================
  // Refill buffer index hold
  //============================================================

  // Stays set only while the refill buffer still matches
  // and the instruction needs the hold
  assign hit_rb_idx_nxt = hit_rb_idx && rb_hit_idx && rb_hold_cond;

  always_ff @(posedge wmb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      hit_rb_idx <= 1'b0;
    else if (create_dp_vld)
      hit_rb_idx <= create_ctl.hit_rb_idx;
    else if (ce_vld)
      hit_rb_idx <= hit_rb_idx_nxt;
  end

  // Second stage releases one cycle after the first
  always_ff @(posedge wmb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      hit_rb_idx_ff <= 1'b0;
    else if (create_dp_vld)
      hit_rb_idx_ff <= create_ctl.hit_rb_idx;
    else if (ce_vld)
      hit_rb_idx_ff <= hit_rb_idx;
  end

  //============================================================
  // Checks
  //============================================================

  // A created entry always has its payload written
  a_create_has_dp: assert property (
    @(posedge wmb_clk) disable iff (!cpurst_b)
    create_vld |-> create_dp_vld
  ) else $error("create_vld without create_dp_vld");

  // Merge target is a single buffer entry
  a_merge_ptr_onehot: assert property (
    @(posedge wmb_clk) disable iff (!cpurst_b)
    (ce_vld && ce_ctl.merge) |-> $onehot(ce_ctl.merge_ptr)
  ) else $error("merge_ptr not one-hot on a merging entry");

endmodule

//--- verilog/wmb_ce_pkg.sv
`include "wmb_ce_settings.svh"

package wmb_ce_pkg;

  //============================================================
  // Opcode encodings
  //============================================================

  // Type field of a popped store with meaning set by atomic and icc
  typedef enum logic [1:0] {
    TYPE_00     = 2'b00,
    TYPE_01     = 2'b01,
    TYPE_DCACHE = 2'b10
  } ce_inst_type_e;

  // Decoded class of the held entry
  typedef enum logic [2:0] {
    CLS_ST,
    CLS_STAMO,
    CLS_SC,
    CLS_AMO_OTHER,
    CLS_SYNC_FENCE,
    CLS_TLBI,
    CLS_DCACHE,
    CLS_ICC_OTHER
  } ce_class_e;

  //============================================================
  // Store and entry payloads
  //============================================================

  // Page attributes with buf carried as bufferable
  typedef struct packed {
    logic ca;
    logic wa;
    logic so;
    logic sec;
    logic bufferable;
    logic share;
  } ce_page_t;

  // One store popped from the store queue
  typedef struct packed {
    logic [`WMB_CE_PA_WIDTH-1:0] addr;
    ce_page_t                    page;
    logic                        atomic;
    logic                        icc;
    logic                        wo_st;
    logic                        sync_fence;
    logic                        inst_flush;
    ce_inst_type_e               inst_type;
    logic [2:0]                  inst_size;
    logic [1:0]                  inst_mode;
    logic [`WMB_CE_BYTES-1:0]    bytes_vld;
    logic [1:0]                  priv_mode;
    logic [`WMB_CE_SQ_PTR_W-1:0] sq_ptr;
  } ce_pop_info_t;

  // Merge decision made by the store queue at create time
  typedef struct packed {
    logic                         merge;
    logic                         stall;
    logic [`WMB_CE_WMB_ENTRY-1:0] merge_ptr;
    logic [`WMB_CE_WMB_ENTRY-1:0] same_dcache_line;
    logic                         hit_rb_idx;
  } ce_create_ctl_t;

  // Requests towards the write-merge buffer
  typedef struct packed {
    logic merge_wmb_req;
    logic merge_wait_not_vld_req;
    logic create_wmb_req;
    logic create_dp_req;
    logic create_data_req;
  } ce_req_t;

  // Attributes handed to the allocated entry
  typedef struct packed {
    logic merge_en;
    logic write_imme;
    logic wb_cmplt_success;
    logic wb_data_success;
    logic read_dp_req;
    logic write_biu_dp_req;
    logic ca_st_inst;
    logic dcache_inst;
    logic dcache_sw_inst;
    logic bytes_vld_full;
  } ce_attr_t;

endpackage

//--- verilog/wmb_ce_pop_compare.sv
`timescale 1ns/10ps
`include "wmb_ce_settings.svh"

module wmb_ce_pop_compare
  import wmb_ce_pkg::*;
(
  input  logic         wmb_clk,
  input  logic         cpurst_b,
  input  logic         ce_vld,
  input  ce_pop_info_t ce_info,
  input  ce_class_e    ce_class,
  input  logic         merge_en,
  input  ce_pop_info_t sq_pop,
  output logic         hit_sq_pop_dcache_line,
  output logic         merge_data_addr_hit,
  output logic         merge_data_stall
);

  logic line_hit;
  logic qw_in_line_hit;

  // Address above the line offset
  assign line_hit = ce_info.addr[`WMB_CE_PA_WIDTH-1:`WMB_CE_LINE_LSB]
                    == sq_pop.addr[`WMB_CE_PA_WIDTH-1:`WMB_CE_LINE_LSB];

  // Quadword index within the line
  assign qw_in_line_hit = ce_info.addr[`WMB_CE_LINE_LSB-1:`WMB_CE_QW_LSB]
                          == sq_pop.addr[`WMB_CE_LINE_LSB-1:`WMB_CE_QW_LSB];

  assign hit_sq_pop_dcache_line = ce_vld && (ce_class == CLS_ST) && line_hit;

  assign merge_data_addr_hit = ce_vld && merge_en && line_hit && qw_in_line_hit;

  // Different privilege cannot merge into the same quadword
  assign merge_data_stall = merge_data_addr_hit
                            && (ce_info.priv_mode != sq_pop.priv_mode);

  // Compare results stay defined while an entry is held
  a_cmp_known: assert property (
    @(posedge wmb_clk) disable iff (!cpurst_b)
    ce_vld |-> !$isunknown({hit_sq_pop_dcache_line, merge_data_addr_hit, merge_data_stall})
  ) else $error("unknown pop compare result while the entry is valid");

endmodule

//--- verilog/wmb_ce_settings.svh
`ifndef WMB_CE_SETTINGS_SVH
`define WMB_CE_SETTINGS_SVH

//============================================================
// Write-merge buffer create entry sizes
//============================================================

// Physical address width
`define WMB_CE_PA_WIDTH   40
// Lowest address bit of a cache line
`define WMB_CE_LINE_LSB   6
// Lowest address bit of a 16-byte quadword
`define WMB_CE_QW_LSB     4
// Store bytes carried by one entry
`define WMB_CE_BYTES      16
// One-hot store queue pointer width
`define WMB_CE_SQ_PTR_W   12
// Write-merge buffer entries
`define WMB_CE_WMB_ENTRY  8

`endif

//--- verilog/wmb_ce_top.sv
`timescale 1ns/10ps
`include "wmb_ce_settings.svh"

module wmb_ce_top
  import wmb_ce_pkg::*;
(
  input  logic                         wmb_clk,
  input  logic                         cpurst_b,
  // Store queue side
  input  ce_pop_info_t                 sq_pop,
  input  logic                         create_vld,
  input  logic                         create_dp_vld,
  input  logic                         pop_vld,
  input  logic                         async_flush,
  input  ce_create_ctl_t               create_ctl,
  input  logic                         rb_hit_idx,
  input  logic [`WMB_CE_WMB_ENTRY-1:0] wmb_entry_vld,
  input  logic                         dcache_valid,
  input  logic                         dcache_share,
  input  logic                         lm_sc_fail,
  // Entry state
  output logic                         ce_vld,
  output ce_pop_info_t                 ce_info,
  output logic [`WMB_CE_WMB_ENTRY-1:0] merge_ptr,
  output logic [`WMB_CE_WMB_ENTRY-1:0] same_dcache_line,
  // Requests and attributes
  output ce_req_t                      req,
  output ce_attr_t                     attr,
  // Pop compare
  output logic                         hit_sq_pop_dcache_line,
  output logic                         merge_data_addr_hit,
  output logic                         merge_data_stall
);

  ce_create_ctl_t ce_ctl;
  ce_class_e      ce_class;
  logic           hit_rb_idx_ff;
  logic           rb_hold_cond;

  assign merge_ptr        = ce_ctl.merge_ptr;
  assign same_dcache_line = ce_ctl.same_dcache_line;

  //============================================================
  // Entry register
  //============================================================

  wmb_ce_entry entry_i (
    .wmb_clk       (wmb_clk),
    .cpurst_b      (cpurst_b),
    .async_flush   (async_flush),
    .create_vld    (create_vld),
    .create_dp_vld (create_dp_vld),
    .pop_vld       (pop_vld),
    .sq_pop        (sq_pop),
    .create_ctl    (create_ctl),
    .rb_hit_idx    (rb_hit_idx),
    .rb_hold_cond  (rb_hold_cond),
    .ce_vld        (ce_vld),
    .ce_info       (ce_info),
    .ce_ctl        (ce_ctl),
    .hit_rb_idx_ff (hit_rb_idx_ff)
  );

  //============================================================
  // Decoder and pop comparator
  //============================================================

  wmb_ce_decode decode_i (
    .wmb_clk       (wmb_clk),
    .cpurst_b      (cpurst_b),
    .ce_vld        (ce_vld),
    .ce_info       (ce_info),
    .ce_ctl        (ce_ctl),
    .hit_rb_idx_ff (hit_rb_idx_ff),
    .wmb_entry_vld (wmb_entry_vld),
    .dcache_valid  (dcache_valid),
    .dcache_share  (dcache_share),
    .lm_sc_fail    (lm_sc_fail),
    .ce_class      (ce_class),
    .rb_hold_cond  (rb_hold_cond),
    .req           (req),
    .attr          (attr)
  );

  wmb_ce_pop_compare compare_i (
    .wmb_clk                (wmb_clk),
    .cpurst_b               (cpurst_b),
    .ce_vld                 (ce_vld),
    .ce_info                (ce_info),
    .ce_class               (ce_class),
    .merge_en               (attr.merge_en),
    .sq_pop                 (sq_pop),
    .hit_sq_pop_dcache_line (hit_sq_pop_dcache_line),
    .merge_data_addr_hit    (merge_data_addr_hit),
    .merge_data_stall       (merge_data_stall)
  );

endmodule

//--- vlog.f
+incdir+verilog
verilog/wmb_ce_pkg.sv
verilog/wmb_ce_entry.sv
verilog/wmb_ce_decode.sv
verilog/wmb_ce_pop_compare.sv
verilog/wmb_ce_top.sv
test/tb_wmb_ce.sv
